//--- Bender.yml
package:
  name: mmu

sources:
  - logic/mmu_pkg.sv
  - logic/mem_map.sv
  - logic/tlb_lookup.sv
  - logic/tlb.sv
  - logic/mmu_top.sv
  - target: test
    files:
      - tests/mmu_tb.sv

//--- logic/mem_map.sv
`timescale 1ns/10ps
`default_nettype none

module mem_map import mmu_pkg::*; (
  input  addr_t addr_i,
  input  logic  en_i,
  input  logic  user_mode_i,
  output addr_t addr_o,
  output logic  mapped_o,
  output logic  uncached_o,
  output logic  illegal_o
);

  segment_e segment;
  logic     seg_mapped;
  logic     illegal;

  // **************************************************
  // Segment decode
  // **************************************************

  always_comb begin
    case (addr_i[31:29])
      3'b100:  segment = seg_kseg0;
      3'b101:  segment = seg_kseg1;
      3'b110,
      3'b111:  segment = seg_kseg23;
      default: segment = seg_kuseg;     // Bit 31 clear
    endcase
  end

  assign seg_mapped = (segment == seg_kuseg) || (segment == seg_kseg23);

  // Unmapped segments drop the top three bits
  always_comb begin
    if (seg_mapped) begin
      addr_o = addr_i;
    end else begin
      addr_o = {3'b000, addr_i[28:0]};
    end
  end

  assign uncached_o = (segment == seg_kseg1);

  // **************************************************
  // Exceptions and TLB request
  // **************************************************

  // User mode may only touch the lower half
  assign illegal   = en_i && user_mode_i && addr_i[31];
  assign illegal_o = illegal;

  // Only an enabled, legal access goes through the TLB
  assign mapped_o = en_i && !illegal && seg_mapped;

endmodule

`default_nettype wire

//--- logic/mmu_pkg.sv
`default_nettype none

package mmu_pkg;

  // **************************************************
  // Address and page types
  // **************************************************

  typedef logic [31:0] addr_t;          // Virtual or physical byte address
  typedef logic [18:0] vpn2_t;          // Virtual bits 31..13, one even/odd page pair
  typedef logic [19:0] pfn_t;           // Physical bits 31..12

  localparam int OFFSET_W = 12;         // 4 KiB pages

  // Fixed segments of the virtual address space
  typedef enum logic [1:0] {
    seg_kuseg  = 2'd0,                  // Mapped, cached, user accessible
    seg_kseg0  = 2'd1,                  // Unmapped, cached
    seg_kseg1  = 2'd2,                  // Unmapped, uncached
    seg_kseg23 = 2'd3                   // Mapped, cached
  } segment_e;

  // **************************************************
  // TLB config word layout
  // **************************************************

  // Low bit of each field
  localparam int VALID1_BIT = 0;
  localparam int PFN1_LSB   = 1;        // Bits 20..1
  localparam int VALID0_BIT = 21;
  localparam int PFN0_LSB   = 22;       // Bits 41..22
  localparam int VPN2_LSB   = 42;       // Bits 60..42

  // Entry body without the index, the index sits right above it
  localparam int ENTRY_BODY_W = 61;
  localparam int INDEX_LSB    = ENTRY_BODY_W;

endpackage

`default_nettype wire

//--- logic/mmu_top.sv
`timescale 1ns/10ps
`default_nettype none

module mmu_top import mmu_pkg::*; #(
  parameter int TLB_ENTRIES = 16
) (
  input  logic                                         clk,
  input  logic                                         rst_i,
  input  addr_t                                        inst_addr_i,
  input  addr_t                                        data_addr_i,
  input  logic                                         inst_en_i,
  input  logic                                         data_en_i,
  input  logic                                         user_mode_i,
  input  logic [ENTRY_BODY_W+$clog2(TLB_ENTRIES)-1:0] tlb_config_i,
  input  logic                                         tlb_write_i,
  output addr_t                                        inst_addr_o,
  output addr_t                                        data_addr_o,
  output logic                                         inst_uncached_o,
  output logic                                         data_uncached_o,
  output logic                                         inst_miss_o,
  output logic                                         data_miss_o,
  output logic                                         inst_illegal_o,
  output logic                                         data_illegal_o
);

  addr_t inst_addr_direct;
  addr_t data_addr_direct;
  addr_t inst_addr_tlb;
  addr_t data_addr_tlb;
  logic  inst_mapped;
  logic  data_mapped;
  logic  inst_tlb_miss;
  logic  data_tlb_miss;

  // **************************************************
  // Segment decoders
  // **************************************************

  mem_map map_inst (
    .addr_i     (inst_addr_i),
    .en_i       (inst_en_i),
    .user_mode_i(user_mode_i),
    .addr_o     (inst_addr_direct),
    .mapped_o   (inst_mapped),
    .uncached_o (inst_uncached_o),
    .illegal_o  (inst_illegal_o)
  );

  mem_map map_data (
    .addr_i     (data_addr_i),
    .en_i       (data_en_i),
    .user_mode_i(user_mode_i),
    .addr_o     (data_addr_direct),
    .mapped_o   (data_mapped),
    .uncached_o (data_uncached_o),
    .illegal_o  (data_illegal_o)
  );

  // Both ports looked up in the same cycle
  tlb #(
    .TLB_ENTRIES(TLB_ENTRIES)
  ) tlb_0 (
    .clk         (clk),
    .rst_i       (rst_i),
    .tlb_write_i (tlb_write_i),
    .tlb_config_i(tlb_config_i),
    .inst_vaddr_i(inst_addr_i),
    .data_vaddr_i(data_addr_i),
    .inst_paddr_o(inst_addr_tlb),
    .data_paddr_o(data_addr_tlb),
    .inst_miss_o (inst_tlb_miss),
    .data_miss_o (data_tlb_miss)
  );

  // **************************************************
  // Final address and miss
  // **************************************************

  assign inst_addr_o = inst_mapped ? inst_addr_tlb : inst_addr_direct;
  assign data_addr_o = data_mapped ? data_addr_tlb : data_addr_direct;

  assign inst_miss_o = inst_tlb_miss && inst_mapped;  // Unmapped access never misses
  assign data_miss_o = data_tlb_miss && data_mapped;

endmodule

`default_nettype wire

//--- logic/tlb.sv
`timescale 1ns/10ps
`default_nettype none

module tlb import mmu_pkg::*; #(
  parameter int TLB_ENTRIES = 16
) (
  input  logic                                         clk,
  input  logic                                         rst_i,
  input  logic                                         tlb_write_i,
  input  logic [ENTRY_BODY_W+$clog2(TLB_ENTRIES)-1:0] tlb_config_i,
  input  addr_t                                        inst_vaddr_i,
  input  addr_t                                        data_vaddr_i,
  output addr_t                                        inst_paddr_o,
  output addr_t                                        data_paddr_o,
  output logic                                         inst_miss_o,
  output logic                                         data_miss_o
);

  localparam int INDEX_W = $clog2(TLB_ENTRIES);

  // Entry storage
  vpn2_t [TLB_ENTRIES-1:0] vpn2_q;
  pfn_t  [TLB_ENTRIES-1:0] pfn0_q;
  pfn_t  [TLB_ENTRIES-1:0] pfn1_q;
  logic  [TLB_ENTRIES-1:0] valid0_q;
  logic  [TLB_ENTRIES-1:0] valid1_q;

  // Fields of the config word
  logic [INDEX_W-1:0] wr_index;
  vpn2_t              wr_vpn2;
  pfn_t               wr_pfn0;
  pfn_t               wr_pfn1;
  logic               wr_valid0;
  logic               wr_valid1;

  // **************************************************
  // Config word decode
  // **************************************************

  assign wr_index  = tlb_config_i[INDEX_LSB +: INDEX_W];
  assign wr_vpn2   = tlb_config_i[VPN2_LSB +: $bits(vpn2_t)];
  assign wr_pfn0   = tlb_config_i[PFN0_LSB +: $bits(pfn_t)];
  assign wr_pfn1   = tlb_config_i[PFN1_LSB +: $bits(pfn_t)];
  assign wr_valid0 = tlb_config_i[VALID0_BIT];
  assign wr_valid1 = tlb_config_i[VALID1_BIT];

  // **************************************************
  // Entry write
  // **************************************************

  always_ff @(posedge clk) begin
    if (tlb_write_i) begin
      vpn2_q[wr_index] <= wr_vpn2;
      pfn0_q[wr_index] <= wr_pfn0;
      pfn1_q[wr_index] <= wr_pfn1;
    end
  end

  // All entries invalid out of reset
  always_ff @(posedge clk) begin
    if (rst_i) begin
      valid0_q <= '0;
      valid1_q <= '0;
    end else if (tlb_write_i) begin
      valid0_q[wr_index] <= wr_valid0;
      valid1_q[wr_index] <= wr_valid1;
    end
  end

  // **************************************************
  // Lookup ports
  // **************************************************

  tlb_lookup #(
    .TLB_ENTRIES(TLB_ENTRIES)
  ) lookup_inst (
    .vaddr_i       (inst_vaddr_i),
    .entry_vpn2_i  (vpn2_q),
    .entry_pfn0_i  (pfn0_q),
    .entry_pfn1_i  (pfn1_q),
    .entry_valid0_i(valid0_q),
    .entry_valid1_i(valid1_q),
    .paddr_o       (inst_paddr_o),
    .miss_o        (inst_miss_o)
  );

  tlb_lookup #(
    .TLB_ENTRIES(TLB_ENTRIES)
  ) lookup_data (
    .vaddr_i       (data_vaddr_i),
    .entry_vpn2_i  (vpn2_q),
    .entry_pfn0_i  (pfn0_q),
    .entry_pfn1_i  (pfn1_q),
    .entry_valid0_i(valid0_q),
    .entry_valid1_i(valid1_q),
    .paddr_o       (data_paddr_o),
    .miss_o        (data_miss_o)
  );

endmodule

`default_nettype wire

//--- logic/tlb_lookup.sv
`timescale 1ns/10ps
`default_nettype none

module tlb_lookup import mmu_pkg::*; #(
  parameter int TLB_ENTRIES = 16
) (
  input  addr_t                   vaddr_i,
  input  vpn2_t [TLB_ENTRIES-1:0] entry_vpn2_i,
  input  pfn_t  [TLB_ENTRIES-1:0] entry_pfn0_i,
  input  pfn_t  [TLB_ENTRIES-1:0] entry_pfn1_i,
  input  logic  [TLB_ENTRIES-1:0] entry_valid0_i,
  input  logic  [TLB_ENTRIES-1:0] entry_valid1_i,
  output addr_t                   paddr_o,
  output logic                    miss_o
);

  vpn2_t                  vpn2;
  logic                   odd_page;
  logic [TLB_ENTRIES-1:0] match;
  logic                   hit;
  pfn_t                   hit_pfn;
  logic                   hit_valid;

  assign vpn2     = vaddr_i[31:OFFSET_W+1];
  assign odd_page = vaddr_i[OFFSET_W];  // Selects pfn1/valid1

  // **************************************************
  // Compare against every entry
  // **************************************************

  always_comb begin
    for (int i = 0; i < TLB_ENTRIES; i++) begin
      match[i] = (entry_vpn2_i[i] == vpn2);
    end
  end

  // Walk from the top down so the lowest matching index is kept
  always_comb begin
    hit       = 1'b0;
    hit_pfn   = '0;
    hit_valid = 1'b0;
    for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
      if (match[i]) begin
        hit = 1'b1;
        if (odd_page) begin
          hit_pfn   = entry_pfn1_i[i];
          hit_valid = entry_valid1_i[i];
        end else begin
          hit_pfn   = entry_pfn0_i[i];
          hit_valid = entry_valid0_i[i];
        end
      end
    end
  end

  // **************************************************
  // Result
  // **************************************************

  assign paddr_o = {hit_pfn, vaddr_i[OFFSET_W-1:0]};

  // Invalid half of a matching pair counts as a miss too
  assign miss_o = !hit || !hit_valid;

endmodule

`default_nettype wire

//--- src.f
logic/mmu_pkg.sv
logic/mem_map.sv
logic/tlb_lookup.sv
logic/tlb.sv
logic/mmu_top.sv
tests/mmu_tb.sv

//--- tests/mmu_tb.sv
`timescale 1ns/10ps
`default_nettype none

module mmu_tb import mmu_pkg::*; ();

  localparam int TLB_ENTRIES  = 16;
  localparam int INDEX_W      = $clog2(TLB_ENTRIES);
  localparam int CFG_W        = ENTRY_BODY_W + INDEX_W;
  localparam int HALF_PERIOD  = 50;
  localparam int SAMPLE_DELAY = HALF_PERIOD - 10;  // Just before the next rising edge
  localparam int RESET_CYCLES = 5;
  localparam int MAX_VEC      = 32;

  logic             clk;
  logic             rst_i;
  addr_t            inst_addr_i;
  addr_t            data_addr_i;
  logic             inst_en_i;
  logic             data_en_i;
  logic             user_mode_i;
  logic [CFG_W-1:0] tlb_config_i;
  logic             tlb_write_i;
  addr_t            inst_addr_o;
  addr_t            data_addr_o;
  logic             inst_uncached_o;
  logic             data_uncached_o;
  logic             inst_miss_o;
  logic             data_miss_o;
  logic             inst_illegal_o;
  logic             data_illegal_o;

  // Expected flags are {inst_unc, data_unc, inst_miss, data_miss, inst_ill, data_ill}
  string            vec_name [0:MAX_VEC-1];
  logic             vec_write [0:MAX_VEC-1];
  logic [CFG_W-1:0] vec_cfg [0:MAX_VEC-1];
  addr_t            vec_inst_addr [0:MAX_VEC-1];
  addr_t            vec_data_addr [0:MAX_VEC-1];
  logic [2:0]       vec_ctrl [0:MAX_VEC-1];        // {inst_en, data_en, user_mode}
  addr_t            vec_exp_inst_addr [0:MAX_VEC-1];
  addr_t            vec_exp_data_addr [0:MAX_VEC-1];
  logic [5:0]       vec_exp_flags [0:MAX_VEC-1];

  int     num_vec       = 0;
  int     pass_count    = 0;
  int     fail_count    = 0;
  int     cycle_count   = 0;
  int     timeout_limit = 1000;
  logic   test_failed;
  integer seed          = 32'hb856;
  logic [11:0] off_a;
  logic [11:0] off_b;

  mmu_top #(
    .TLB_ENTRIES(TLB_ENTRIES)
  ) mmu_top_i (
    .clk            (clk),
    .rst_i          (rst_i),
    .inst_addr_i    (inst_addr_i),
    .data_addr_i    (data_addr_i),
    .inst_en_i      (inst_en_i),
    .data_en_i      (data_en_i),
    .user_mode_i    (user_mode_i),
    .tlb_config_i   (tlb_config_i),
    .tlb_write_i    (tlb_write_i),
    .inst_addr_o    (inst_addr_o),
    .data_addr_o    (data_addr_o),
    .inst_uncached_o(inst_uncached_o),
    .data_uncached_o(data_uncached_o),
    .inst_miss_o    (inst_miss_o),
    .data_miss_o    (data_miss_o),
    .inst_illegal_o (inst_illegal_o),
    .data_illegal_o (data_illegal_o)
  );

  always #(HALF_PERIOD) clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_limit) begin
      $display("Timeout: the test sequence did not finish within %0d cycles", timeout_limit);
      $display("Simulation FAILED");
      $finish;
    end
  end

  // **************************************************
  // Table helpers
  // **************************************************

  function automatic logic [CFG_W-1:0] make_config(input int index, input vpn2_t vpn2,
                                                   input pfn_t pfn0, input logic valid0,
                                                   input pfn_t pfn1, input logic valid1);
    logic [CFG_W-1:0] cfg;
    cfg = '0;
    cfg[INDEX_LSB +: INDEX_W]       = index[INDEX_W-1:0];
    cfg[VPN2_LSB +: $bits(vpn2_t)]  = vpn2;
    cfg[PFN0_LSB +: $bits(pfn_t)]   = pfn0;
    cfg[VALID0_BIT]                 = valid0;
    cfg[PFN1_LSB +: $bits(pfn_t)]   = pfn1;
    cfg[VALID1_BIT]                 = valid1;
    return cfg;
  endfunction

  task automatic add_write(input string name, input logic [CFG_W-1:0] cfg);
    vec_name[num_vec]  = name;
    vec_write[num_vec] = 1'b1;
    vec_cfg[num_vec]   = cfg;
    num_vec++;
  endtask

  task automatic add_lookup(input string name, input addr_t ia, input addr_t da,
                            input logic [2:0] ctrl, input addr_t exp_ia, input addr_t exp_da,
                            input logic [5:0] flags);
    vec_name[num_vec]          = name;
    vec_write[num_vec]         = 1'b0;
    vec_cfg[num_vec]           = '0;
    vec_inst_addr[num_vec]     = ia;
    vec_data_addr[num_vec]     = da;
    vec_ctrl[num_vec]          = ctrl;
    vec_exp_inst_addr[num_vec] = exp_ia;
    vec_exp_data_addr[num_vec] = exp_da;
    vec_exp_flags[num_vec]     = flags;
    num_vec++;
  endtask

  task automatic check_value(input string test_name, input string field,
                             input logic [31:0] expected, input logic [31:0] actual);
    if (actual !== expected) begin
      $display("Mismatch in %s: %s expected %h actual %h", test_name, field, expected, actual);
      test_failed = 1'b1;
    end
  endtask

  // **************************************************
  // Vector execution
  // **************************************************

  task automatic run_vector(input int i);
    logic [5:0] flags;
    flags = vec_exp_flags[i];
    @(negedge clk);
    test_failed = 1'b0;
    if (vec_write[i]) begin
      tlb_config_i = vec_cfg[i];
      tlb_write_i  = 1'b1;
      @(negedge clk);
      tlb_write_i  = 1'b0;                     // Idle cycle follows
      $display("DONE  %s", vec_name[i]);
    end else begin
      inst_addr_i = vec_inst_addr[i];
      data_addr_i = vec_data_addr[i];
      {inst_en_i, data_en_i, user_mode_i} = vec_ctrl[i];
      #(SAMPLE_DELAY);
      // Address is meaningless on a miss
      if (!flags[3]) check_value(vec_name[i], "inst_addr", vec_exp_inst_addr[i], inst_addr_o);
      if (!flags[2]) check_value(vec_name[i], "data_addr", vec_exp_data_addr[i], data_addr_o);
      check_value(vec_name[i], "inst_uncached", flags[5], inst_uncached_o);
      check_value(vec_name[i], "data_uncached", flags[4], data_uncached_o);
      check_value(vec_name[i], "inst_miss", flags[3], inst_miss_o);
      check_value(vec_name[i], "data_miss", flags[2], data_miss_o);
      check_value(vec_name[i], "inst_illegal", flags[1], inst_illegal_o);
      check_value(vec_name[i], "data_illegal", flags[0], data_illegal_o);
      if (test_failed) begin
        fail_count++;
        $display("FAIL  %s", vec_name[i]);
      end else begin
        pass_count++;
        $display("PASS  %s", vec_name[i]);
      end
    end
  endtask

  initial begin
    clk          = 1'b0;
    rst_i        = 1'b1;
    inst_addr_i  = '0;
    data_addr_i  = '0;
    inst_en_i    = 1'b0;
    data_en_i    = 1'b0;
    user_mode_i  = 1'b0;
    tlb_config_i = '0;
    tlb_write_i  = 1'b0;

    // Reset state and unmapped segments
    add_lookup("reset_idle", 32'h0000_1000, 32'h0000_2000, 3'b000,
               32'h0000_1000, 32'h0000_2000, 6'b000000);
    add_lookup("empty_kuseg_miss", 32'h0040_0000, 32'h0040_1000, 3'b110,
               32'h0, 32'h0, 6'b001100);
    add_lookup("kseg0_kseg1_direct", 32'h8001_2345, 32'hA040_0010, 3'b110,
               32'h0001_2345, 32'h0040_0010, 6'b010000);
    add_lookup("kseg1_kseg0_direct", 32'hBFC0_0180, 32'h8000_4000, 3'b110,
               32'h1FC0_0180, 32'h0000_4000, 6'b100000);

    // Mapped kuseg and kseg2 pages
    add_write("write_entry3", make_config(3, 19'h00200, 20'h12345, 1'b1, 20'h23456, 1'b1));
    add_lookup("kuseg_even_odd", 32'h0040_0ABC, 32'h0040_1DEF, 3'b110,
               32'h1234_5ABC, 32'h2345_6DEF, 6'b000000);
    add_write("write_entry5", make_config(5, 19'h60000, 20'h0ABCD, 1'b1, 20'h0BCDE, 1'b1));
    add_lookup("kseg2_even_odd", 32'hC000_0123, 32'hC000_1FFF, 3'b110,
               32'h0ABC_D123, 32'h0BCD_EFFF, 6'b000000);
    off_a = $random(seed);
    off_b = $random(seed);
    add_lookup("random_offsets_kuseg", {20'h00400, off_a}, {20'h00401, off_b}, 3'b110,
               {20'h12345, off_a}, {20'h23456, off_b}, 6'b000000);
    off_a = $random(seed);
    off_b = $random(seed);
    add_lookup("random_offsets_kseg2", {20'hC0001, off_a}, {20'hC0000, off_b}, 3'b110,
               {20'h0BCDE, off_a}, {20'h0ABCD, off_b}, 6'b000000);

    // Invalid half and overwrite
    add_write("write_entry7", make_config(7, 19'h00400, 20'h11111, 1'b0, 20'h22222, 1'b1));
    add_lookup("half_invalid", 32'h0080_0100, 32'h0080_1100, 3'b110,
               32'h0, 32'h2222_2100, 6'b001000);
    add_write("overwrite_entry3", make_config(3, 19'h00300, 20'h33333, 1'b1, 20'h44444, 1'b1));
    add_lookup("overwrite_replaces", 32'h0040_0ABC, 32'h0060_0ABC, 3'b110,
               32'h0, 32'h3333_3ABC, 6'b001000);

    // User mode
    add_lookup("user_kseg0_illegal", 32'h8000_0000, 32'h0060_1004, 3'b111,
               32'h0000_0000, 32'h4444_4004, 6'b000010);
    add_lookup("user_kseg2_illegal", 32'h0060_0010, 32'hC000_0123, 3'b111,
               32'h3333_3010, 32'hC000_0123, 6'b000001);
    add_lookup("user_enable_low", 32'h8000_0000, 32'h0090_0000, 3'b001,
               32'h0000_0000, 32'h0090_0000, 6'b000000);

    // Independent ports through different entries
    add_lookup("dual_port_a", 32'hC000_1234, 32'h0080_1ABC, 3'b110,
               32'h0BCD_E234, 32'h2222_2ABC, 6'b000000);
    add_lookup("dual_port_b", 32'h0060_1004, 32'hC000_0FFC, 3'b110,
               32'h4444_4004, 32'h0ABC_DFFC, 6'b000000);

    timeout_limit = 2 * num_vec + RESET_CYCLES + 20;

    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_i = 1'b0;

    for (int i = 0; i < num_vec; i++) begin
      run_vector(i);
    end

    $display("Tests finished: %0d passed, %0d failed", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
